/* logic/operand_counter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pow5_defs.svh"

module operand_counter (
    input  logic              slow_clk,
    input  logic              rst,
    input  logic [3:0]        key,
    output logic              up_vld,
    output pow5_pkg::data_t   up_data
);

    // Just wide enough for 0..max operand
    localparam int cnt_w = $clog2(`POW5_MAX_OPERAND + 1);

    logic [cnt_w - 1:0] cnt;

    // Any key held means a new operand this cycle
    assign up_vld = |key;

    // Wrapping operand counter, steps once per valid cycle
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (up_vld) begin
            if (cnt == cnt_w'(`POW5_MAX_OPERAND)) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Zero-extend to the data width
    assign up_data = pow5_pkg::data_t'(cnt);

endmodule

`default_nettype wire

/* logic/pow5_defs.svh */
`ifndef POW5_DEFS_SVH
`define POW5_DEFS_SVH

// ----------------------------------------------------------
// Data path
// ----------------------------------------------------------

// Operand and result width, results are taken modulo 2**12
`define POW5_WIDTH 12

// Highest operand before the counter wraps back to zero
`define POW5_MAX_OPERAND 5

// ----------------------------------------------------------
// Display
// ----------------------------------------------------------

// Digits on the scanned seven-segment display
`define POW5_DIGITS 4

// Clock cycles each digit stays selected
`define POW5_SCAN_CYCLES 4

`endif

/* logic/pow5_lab_top.sv */
`timescale 1ns/100ps
`default_nettype none

module pow5_lab_top (
    input  logic              slow_clk,
    input  logic              rst,
    input  logic [3:0]        key,
    output logic [3:0]        led,
    output pow5_pkg::seg_t    abcdefgh,
    output pow5_pkg::digit_t  digit
);

    // ----------------------------------------------------------
    // Interconnect
    // ----------------------------------------------------------

    // Upstream side
    logic            up_vld;
    pow5_pkg::data_t up_data;

    // Downstream side
    logic            down_vld;
    pow5_pkg::data_t down_data;
    pow5_pkg::data_t down_operand;

    // ----------------------------------------------------------
    // Input, processing, output
    // ----------------------------------------------------------

    operand_counter u_in (
        .slow_clk (slow_clk),
        .rst      (rst),
        .key      (key),
        .up_vld   (up_vld),
        .up_data  (up_data)
    );

    pow5_pipe u_proc (
        .slow_clk     (slow_clk),
        .rst          (rst),
        .up_vld       (up_vld),
        .up_data      (up_data),
        .down_vld     (down_vld),
        .down_data    (down_data),
        .down_operand (down_operand)
    );

    seg7_scan u_out (
        .slow_clk     (slow_clk),
        .rst          (rst),
        .down_vld     (down_vld),
        .down_data    (down_data),
        .down_operand (down_operand),
        .abcdefgh     (abcdefgh),
        .digit        (digit)
    );

    // ----------------------------------------------------------
    // Status LEDs
    // ----------------------------------------------------------

    // Upstream valid on led[3], downstream valid on led[1]
    assign led = {up_vld, 1'b0, down_vld, 1'b0};

endmodule

`default_nettype wire

/* logic/pow5_pipe.sv */
`timescale 1ns/100ps
`default_nettype none

module pow5_pipe (
    input  logic              slow_clk,
    input  logic              rst,
    input  logic              up_vld,
    input  pow5_pkg::data_t   up_data,
    output logic              down_vld,
    output pow5_pkg::data_t   down_data,
    output pow5_pkg::data_t   down_operand
);

    // ----------------------------------------------------------
    // Stage registers
    // ----------------------------------------------------------

    logic            s1_vld;
    pow5_pkg::data_t s1_op;
    pow5_pkg::data_t s1_sq;

    logic            s2_vld;
    pow5_pkg::data_t s2_op;
    pow5_pkg::data_t s2_p4;

    logic            s3_vld;
    pow5_pkg::data_t s3_op;
    pow5_pkg::data_t s3_p5;

    // ----------------------------------------------------------
    // Valid chain
    // ----------------------------------------------------------

    // No stalls, valid simply shifts one stage per cycle
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
            s3_vld <= 1'b0;
        end else begin
            s1_vld <= up_vld;
            s2_vld <= s1_vld;
            s3_vld <= s2_vld;
        end
    end

    // ----------------------------------------------------------
    // Data path
    // ----------------------------------------------------------

    // Stage 1: x and x^2
    always_ff @(posedge slow_clk) begin
        if (up_vld) begin
            s1_op <= up_data;
            s1_sq <= up_data * up_data;
        end
    end

    // Stage 2: x and x^4
    always_ff @(posedge slow_clk) begin
        if (s1_vld) begin
            s2_op <= s1_op;
            s2_p4 <= s1_sq * s1_sq;
        end
    end

    // Stage 3: x and x^5, all products wrap at the data width
    always_ff @(posedge slow_clk) begin
        if (s2_vld) begin
            s3_op <= s2_op;
            s3_p5 <= s2_p4 * s2_op;
        end
    end

    // ----------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------

    assign down_vld     = s3_vld;
    assign down_data    = s3_p5;
    assign down_operand = s3_op;

endmodule

`default_nettype wire

/* logic/pow5_pkg.sv */
`default_nettype none

`include "pow5_defs.svh"

package pow5_pkg;

    // ----------------------------------------------------------
    // Data path types
    // ----------------------------------------------------------

    // Operand or result word
    typedef logic [`POW5_WIDTH - 1:0] data_t;

    // ----------------------------------------------------------
    // Display types
    // ----------------------------------------------------------

    // Segments a..g then dot, a in the top bit, active high
    typedef logic [7:0] seg_t;

    // One-hot digit enables, active high
    // Bit 3 is the leftmost digit
    typedef logic [`POW5_DIGITS - 1:0] digit_t;

endpackage

`default_nettype wire

/* logic/seg7_scan.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pow5_defs.svh"

module seg7_scan (
    input  logic              slow_clk,
    input  logic              rst,
    input  logic              down_vld,
    input  pow5_pkg::data_t   down_data,
    input  pow5_pkg::data_t   down_operand,
    output pow5_pkg::seg_t    abcdefgh,
    output pow5_pkg::digit_t  digit
);

    localparam int idx_w   = $clog2(`POW5_DIGITS);
    localparam int presc_w = $clog2(`POW5_SCAN_CYCLES + 1);

    // Leftmost digit carries the operand
    localparam logic [idx_w - 1:0] op_idx = idx_w'(`POW5_DIGITS - 1);

    pow5_pkg::data_t op_q;
    pow5_pkg::data_t res_q;
    logic            shown;

    logic [presc_w - 1:0]         presc;
    logic [idx_w - 1:0]           idx;
    logic [idx_w - 1:0]           sel;
    logic [4 * `POW5_DIGITS - 1:0] disp_word;
    logic [3:0]                   nibble;
    logic                         blank;

    // ----------------------------------------------------------
    // Latest result capture
    // ----------------------------------------------------------

    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            op_q  <= '0;
            res_q <= '0;
            shown <= 1'b0;
        end else if (down_vld) begin
            op_q  <= down_operand;
            res_q <= down_data;
            shown <= 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Digit scan
    // ----------------------------------------------------------

    // Prescaler and index, index counts down 3, 2, 1, 0
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            presc <= '0;
            idx   <= op_idx;
        end else if (presc == presc_w'(`POW5_SCAN_CYCLES - 1)) begin
            presc <= '0;
            if (idx == '0) begin
                idx <= op_idx;
            end else begin
                idx <= idx - 1'b1;
            end
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // Digit enable and its index follow the scan index by one cycle
    // so each position gets a full period
    always_ff @(posedge slow_clk or posedge rst) begin
        if (rst) begin
            digit <= '0;
            sel   <= op_idx;
        end else begin
            digit <= pow5_pkg::digit_t'(1) << idx;
            sel   <= idx;
        end
    end

    // ----------------------------------------------------------
    // Segment decode
    // ----------------------------------------------------------

    // Standard hex font, dot bit always clear
    function automatic pow5_pkg::seg_t hex_to_seg(input logic [3:0] nib);
        pow5_pkg::seg_t seg;
        case (nib)
            4'h0:    seg = 8'b1111_1100;
            4'h1:    seg = 8'b0110_0000;
            4'h2:    seg = 8'b1101_1010;
            4'h3:    seg = 8'b1111_0010;
            4'h4:    seg = 8'b0110_0110;
            4'h5:    seg = 8'b1011_0110;
            4'h6:    seg = 8'b1011_1110;
            4'h7:    seg = 8'b1110_0000;
            4'h8:    seg = 8'b1111_1110;
            4'h9:    seg = 8'b1111_0110;
            4'ha:    seg = 8'b1110_1110;
            4'hb:    seg = 8'b0011_1110;
            4'hc:    seg = 8'b1001_1100;
            4'hd:    seg = 8'b0111_1010;
            4'he:    seg = 8'b1001_1110;
            default: seg = 8'b1000_1110;
        endcase
        return seg;
    endfunction

    // Operand nibble on the left, 12-bit result on the right
    assign disp_word = {op_q[3:0], res_q};
    assign nibble    = disp_word[sel * 4 +: 4];

    // Nothing lit with no digit enabled
    // Result digits stay dark until a result has arrived
    assign blank = (digit == '0) || ((sel != op_idx) && !shown);

    assign abcdefgh = blank ? '0 : hex_to_seg(nibble);

endmodule

`default_nettype wire

/* pow5_lab.f */
+incdir+logic
logic/pow5_pkg.sv
logic/operand_counter.sv
logic/pow5_pipe.sv
logic/seg7_scan.sv
logic/pow5_lab_top.sv
test/tb_pow5_lab.sv

/* test/tb_pow5_lab.sv */
`timescale 1ns/100ps
`default_nettype none

`include "pow5_defs.svh"

module tb_pow5_lab;

    // Stimulus is about 700 cycles, so this leaves a wide margin
    localparam int timeout_cycles = 3000;
    localparam int op_pos         = `POW5_DIGITS - 1;

    // Hex font, a in bit 7 down to g in bit 1, dot in bit 0
    localparam logic [7:0] seg_table [16] = '{
        8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
        8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
    };

    logic             slow_clk;
    logic             rst;
    logic [3:0]       key;
    logic [3:0]       led;
    pow5_pkg::seg_t   abcdefgh;
    pow5_pkg::digit_t digit;

    // Reference model state
    int               m_cnt;
    logic             pipe_vld [3];
    pow5_pkg::data_t  pipe_op [3];
    pow5_pkg::data_t  pipe_res [3];
    pow5_pkg::data_t  m_op;
    pow5_pkg::data_t  m_res;
    logic             m_shown;
    pow5_pkg::digit_t exp_digit;
    int               exp_pos;
    int               exp_hold;
    logic             out_of_reset;
    int               cycle_count;

    pow5_lab_top dut0 (
        .slow_clk (slow_clk),
        .rst      (rst),
        .key      (key),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    initial slow_clk = 1'b0;
    always #4 slow_clk = ~slow_clk;

    // ----------------------------------------------------------
    // Failure handling
    // ----------------------------------------------------------

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    always @(posedge slow_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            stop_with_failure();
        end
    end

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------

    function automatic pow5_pkg::data_t fifth_power(input int x);
        int acc;
        acc = 1;
        repeat (5) begin
            acc = acc * x;
        end
        return pow5_pkg::data_t'(acc % 4096);
    endfunction

    function automatic int next_operand(input int x);
        return (x == `POW5_MAX_OPERAND) ? 0 : x + 1;
    endfunction

    function automatic logic [3:0] nibble_of(input pow5_pkg::data_t word, input int pos);
        return 4'((word >> (pos * 4)) & 12'h00f);
    endfunction

    // Counter mirror and three-deep latency queue
    always @(posedge slow_clk) begin
        if (rst) begin
            m_cnt <= 0;
            for (int i = 0; i < 3; i++) begin
                pipe_vld[i] <= 1'b0;
            end
        end else begin
            if (|key) begin
                m_cnt <= next_operand(m_cnt);
            end
            pipe_vld[0] <= |key;
            pipe_op[0]  <= pow5_pkg::data_t'(m_cnt);
            pipe_res[0] <= fifth_power(m_cnt);
            for (int i = 1; i < 3; i++) begin
                pipe_vld[i] <= pipe_vld[i - 1];
                pipe_op[i]  <= pipe_op[i - 1];
                pipe_res[i] <= pipe_res[i - 1];
            end
        end
    end

    // Last result on the display
    always @(posedge slow_clk) begin
        if (rst) begin
            m_op    <= '0;
            m_res   <= '0;
            m_shown <= 1'b0;
        end else if (pipe_vld[2]) begin
            m_op    <= pipe_op[2];
            m_res   <= pipe_res[2];
            m_shown <= 1'b1;
        end
    end

    // Scan position tracker, 3 2 1 0 with a fixed dwell
    always @(posedge slow_clk) begin
        if (rst) begin
            exp_digit    <= '0;
            exp_pos      <= op_pos;
            exp_hold     <= 0;
            out_of_reset <= 1'b0;
        end else begin
            out_of_reset <= 1'b1;
            if (!out_of_reset) begin
                exp_pos   <= op_pos;
                exp_digit <= pow5_pkg::digit_t'(1) << op_pos;
                exp_hold  <= 1;
            end else if (exp_hold == `POW5_SCAN_CYCLES) begin
                exp_pos   <= (exp_pos == 0) ? op_pos : exp_pos - 1;
                exp_digit <= pow5_pkg::digit_t'(1) << ((exp_pos == 0) ? op_pos : exp_pos - 1);
                exp_hold  <= 1;
            end else begin
                exp_hold <= exp_hold + 1;
            end
        end
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------

    a_reset_state: assert property (@(posedge slow_clk)
        rst |-> (led == 4'b0000 && digit == '0 && abcdefgh == '0))
        else report_mismatch("outputs not cleared during reset");

    a_up_valid: assert property (@(posedge slow_clk) disable iff (rst)
        led[3] == |key)
        else report_mismatch("led[3] does not follow the keys");

    a_down_valid: assert property (@(posedge slow_clk) disable iff (rst)
        led[1] == pipe_vld[2])
        else report_mismatch("led[1] is not led[3] delayed by 3 cycles");

    a_unused_leds: assert property (@(posedge slow_clk)
        (led[2] == 1'b0 && led[0] == 1'b0))
        else report_mismatch("led[2] or led[0] is lit");

    a_onehot: assert property (@(posedge slow_clk) disable iff (rst)
        out_of_reset |-> $onehot(digit))
        else report_mismatch("digit enable is not one-hot");

    a_scan_order: assert property (@(posedge slow_clk) disable iff (rst)
        out_of_reset |-> (digit == exp_digit))
        else report_mismatch("digit scan position or dwell is wrong");

    a_operand_digit: assert property (@(posedge slow_clk) disable iff (rst)
        (out_of_reset && exp_pos == op_pos) |-> (abcdefgh == seg_table[m_op[3:0]]))
        else report_mismatch("operand digit shows the wrong segments");

    a_blank_result: assert property (@(posedge slow_clk) disable iff (rst)
        (out_of_reset && exp_pos != op_pos && !m_shown) |-> (abcdefgh == '0))
        else report_mismatch("result digit lit before the first result");

    a_result_digit: assert property (@(posedge slow_clk) disable iff (rst)
        (out_of_reset && exp_pos != op_pos && m_shown)
        |-> (abcdefgh == seg_table[nibble_of(m_res, exp_pos)]))
        else report_mismatch("result digit shows the wrong segments");

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------

    task automatic hold_keys(input logic [3:0] pattern, input int cycles);
        repeat (cycles) begin
            @(negedge slow_clk);
            key = pattern;
        end
    endtask

    // Let the last items reach the display
    task automatic wait_for_drain();
        while (led[1] || led[3] || pipe_vld[0] || pipe_vld[1] || pipe_vld[2]) begin
            @(negedge slow_clk);
        end
    endtask

    initial begin
        rst         = 1'b1;
        key         = 4'b0000;
        cycle_count = 0;
        void'($urandom(77));

        repeat (8) begin
            @(negedge slow_clk);
        end
        rst = 1'b0;

        // Idle, result digits must stay blank over full scans
        hold_keys(4'b0000, 40);

        // Single presses
        repeat (6) begin
            hold_keys(4'(1 << $urandom_range(3, 0)), 1);
            hold_keys(4'b0000, $urandom_range(20, 5));
        end

        // Back-to-back hold, three items in flight
        hold_keys(4'b0001, 3);
        hold_keys(4'b0000, 6);

        // Random bursts and gaps
        repeat (20) begin
            hold_keys(4'($urandom_range(15, 1)), $urandom_range(8, 1));
            hold_keys(4'b0000, $urandom_range(12, 0));
        end

        // Long hold, counter wraps several times
        repeat (40) begin
            hold_keys(4'($urandom_range(15, 1)), 1);
        end
        hold_keys(4'b0000, 20);

        // Random key pattern every cycle
        repeat (150) begin
            hold_keys(4'($urandom_range(15, 0)), 1);
        end

        hold_keys(4'b0000, 1);
        wait_for_drain();
        hold_keys(4'b0000, 2 * `POW5_DIGITS * `POW5_SCAN_CYCLES);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire
